// File: core_pipeline.f
+incdir+include
hw/rv_isa_pkg.sv
hw/core_pipe_pkg.sv
hw/stage_reg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_pipeline.sv
testbench/core_assertions.sv
testbench/core_checker.sv
testbench/tb_core_pipeline.sv

// File: testbench/tb_core_pipeline.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module tb_core_pipeline;

	localparam int PROG_LEN       = 40;
	localparam int DMEM_WORDS     = 512;
	localparam int TIMEOUT_CYCLES = 40 * PROG_LEN * 8;
	localparam logic [`XLEN-1:0] NOP = 32'h0000_0013;

	logic                     clk;
	logic                     arst_n;
	logic                     inst_start;
	logic                     inst_ready;
	logic [`XLEN-1:0]         i_addr;
	logic [`XLEN-1:0]         inst;
	logic                     inst_valid;
	core_pipe_pkg::dmem_req_t d_req;
	logic                     d_cmd_ready;
	logic [`XLEN-1:0]         rdata;
	logic                     rdata_valid;

	logic [`XLEN-1:0]         prog [PROG_LEN];
	logic [`XLEN-1:0]         dmem_init [DMEM_WORDS];
	logic [`XLEN-1:0]         dmem [DMEM_WORDS];
	logic [15:0]              lfsr;

	// Memory model state
	logic                     i_acc;
	logic [`XLEN-1:0]         i_req_addr;
	logic [`XLEN-1:0]         i_word;
	logic                     i_busy;
	int                       i_lat;
	int                       i_wait;
	logic                     d_acc;
	core_pipe_pkg::dmem_req_t d_seen;
	logic                     d_busy;
	int                       d_lat;
	int                       d_wait;
	logic [8:0]               d_rd_idx;

	logic                     chk_done;
	int                       value_errors;
	int                       count_errors;
	int                       protocol_errors;
	int                       total;

	core_pipeline dut0 (
		.clk(clk), .arst_n(arst_n),
		.inst_start(inst_start), .inst_ready(inst_ready), .i_addr(i_addr),
		.inst(inst), .inst_valid(inst_valid),
		.d_req(d_req), .d_cmd_ready(d_cmd_ready),
		.rdata(rdata), .rdata_valid(rdata_valid)
	);

	core_checker #(.PROG_LEN(PROG_LEN), .DMEM_WORDS(DMEM_WORDS)) chk0 (
		.clk(clk), .arst_n(arst_n),
		.inst_start(inst_start), .inst_ready(inst_ready), .i_addr(i_addr),
		.d_req(d_req), .d_cmd_ready(d_cmd_ready),
		.prog(prog), .dmem_init(dmem_init),
		.done(chk_done), .value_errors(value_errors),
		.count_errors(count_errors), .protocol_errors(protocol_errors)
	);

	// ********************
	// Instruction encoders
	// ********************
	function automatic logic [31:0] reg_op(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
		int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_isa_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] imm_op(logic [2:0] f3, int rd, int rs1, int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), rv_isa_pkg::OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] lw(int rd, int rs1, int imm);
		return {12'(imm), 5'(rs1), 3'b010, 5'(rd), rv_isa_pkg::OPC_LOAD};
	endfunction

	function automatic logic [31:0] sw(int rs2, int rs1, int imm);
		logic [11:0] off;
		off = 12'(imm);
		return {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], rv_isa_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] lui(int rd, int imm);
		return {20'(imm), 5'(rd), rv_isa_pkg::OPC_LUI};
	endfunction

	// Galois LFSR, one step per bit
	function automatic int lfsr_bits(int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			v    = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic load_program();
		// ALU results stored through x2
		prog[0]  = imm_op(rv_isa_pkg::F3_ADD, 5, 0, 123);
		prog[1]  = imm_op(rv_isa_pkg::F3_ADD, 6, 0, -45);
		prog[2]  = sw(5, 2, 0);
		prog[3]  = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 7, 5, 6);
		prog[4]  = reg_op(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD, 8, 5, 6);
		prog[5]  = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND, 9, 5, 6);
		prog[6]  = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR, 10, 5, 6);
		prog[7]  = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 11, 5, 6);
		prog[8]  = sw(7, 2, 4);
		prog[9]  = sw(8, 2, 8);
		prog[10] = sw(9, 2, 12);
		prog[11] = sw(10, 2, 16);
		prog[12] = sw(11, 2, 20);
		prog[13] = imm_op(rv_isa_pkg::F3_AND, 12, 6, 12'h0F0);
		prog[14] = imm_op(rv_isa_pkg::F3_OR, 13, 5, 12'h700);
		prog[15] = imm_op(rv_isa_pkg::F3_XOR, 14, 6, -1);
		prog[16] = sw(12, 2, 24);
		prog[17] = sw(13, 2, 28);
		prog[18] = sw(14, 2, 32);
		// LUI and writes to x0
		prog[19] = lui(15, 20'hABCDE);
		prog[20] = imm_op(rv_isa_pkg::F3_ADD, 15, 15, 12'h123);
		prog[21] = imm_op(rv_isa_pkg::F3_ADD, 0, 5, 77);
		prog[22] = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 16, 0, 15);
		prog[23] = sw(0, 2, 36);
		prog[24] = sw(16, 2, 40);
		// Back-to-back dependent chain on x17
		prog[25] = imm_op(rv_isa_pkg::F3_ADD, 17, 5, 1);
		prog[26] = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 17, 17, 17);
		prog[27] = reg_op(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD, 17, 17, 6);
		prog[28] = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR, 17, 17, 15);
		prog[29] = sw(17, 2, 44);
		// Loads whose value is used at once
		prog[30] = lw(18, 2, 0);
		prog[31] = reg_op(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD, 19, 18, 18);
		prog[32] = sw(19, 2, 48);
		prog[33] = lw(20, 2, -200);
		prog[34] = imm_op(rv_isa_pkg::F3_XOR, 21, 20, 12'h055);
		prog[35] = sw(21, 2, 52);
		prog[36] = lw(22, 2, 4);
		prog[37] = sw(22, 2, -100);
		prog[38] = lui(23, 20'h00012);
		prog[39] = sw(23, 2, 56);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
	end

	// ********************
	// Memory models
	// ********************
	initial begin
		inst_ready  = 1'b0;
		inst        = '0;
		inst_valid  = 1'b0;
		d_cmd_ready = 1'b0;
		rdata       = '0;
		rdata_valid = 1'b0;
		lfsr        = 16'd83;
		i_busy      = 1'b0;
		i_wait      = 0;
		d_busy      = 1'b0;
		d_wait      = 0;
		load_program();
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem_init[i] = (32'(i) * 32'h9E37_79B9) ^ 32'h0BAD_F00D;
		end
		dmem = dmem_init;
		forever begin
			// Handshakes are settled mid-cycle
			@(negedge clk);
			i_acc      = inst_start && inst_ready;
			i_req_addr = i_addr;
			d_acc      = (d_req.cmd != core_pipe_pkg::DMEM_NONE) && d_cmd_ready;
			d_seen     = d_req;
			@(posedge clk);
			#1;
			inst_valid = 1'b0;
			if (i_acc) begin
				inst_ready = 1'b0;
				i_busy     = 1'b1;
				i_lat      = lfsr_bits(2);
				i_word     = (i_req_addr[31:2] < PROG_LEN) ? prog[i_req_addr[31:2]] : NOP;
			end else if (!i_busy) begin
				if (i_wait == 0) begin
					inst_ready = 1'b1;
				end else begin
					i_wait--;
				end
			end
			if (i_busy) begin
				if (i_lat == 0) begin
					inst       = i_word;
					inst_valid = 1'b1;
					i_busy     = 1'b0;
					i_wait     = lfsr_bits(2);
				end else begin
					i_lat--;
				end
			end
			rdata_valid = 1'b0;
			if (d_acc) begin
				d_cmd_ready = 1'b0;
				if (d_seen.cmd == core_pipe_pkg::DMEM_WRITE) begin
					dmem[d_seen.addr[10:2]] = d_seen.wdata;
					d_wait = lfsr_bits(2);
				end else begin
					d_busy   = 1'b1;
					d_lat    = lfsr_bits(2);
					d_rd_idx = d_seen.addr[10:2];
				end
			end else if (!d_busy) begin
				if (d_wait == 0) begin
					d_cmd_ready = 1'b1;
				end else begin
					d_wait--;
				end
			end
			if (d_busy) begin
				if (d_lat == 0) begin
					rdata       = dmem[d_rd_idx];
					rdata_valid = 1'b1;
					d_busy      = 1'b0;
					d_wait      = lfsr_bits(2);
				end else begin
					d_lat--;
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the program did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		wait (chk_done === 1'b1);
		@(posedge clk);
		total = value_errors + count_errors + protocol_errors + dut0.assert0.fail_count;
		$display("Errors: value %0d, store count %0d, protocol %0d, assertion %0d",
			value_errors, count_errors, protocol_errors, dut0.assert0.fail_count);
		if (total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: testbench/core_checker.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module core_checker #(
	parameter int PROG_LEN   = 40,
	parameter int DMEM_WORDS = 512
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     inst_start,
	input  logic                     inst_ready,
	input  logic [`XLEN-1:0]         i_addr,
	input  core_pipe_pkg::dmem_req_t d_req,
	input  logic                     d_cmd_ready,
	input  logic [`XLEN-1:0]         prog [PROG_LEN],
	input  logic [`XLEN-1:0]         dmem_init [DMEM_WORDS],
	output logic                     done,
	output int                       value_errors,
	output int                       count_errors,
	output int                       protocol_errors
);

	// Every store writes the whole word
	localparam logic [`XLEN-1:0] FULL_MASK = '1;

	logic [`XLEN-1:0] exp_addr [$];
	logic [`XLEN-1:0] exp_data [$];
	int               n_store;
	int               n_fetch;
	logic             seen_cmd;

	// ********************
	// Reference interpreter
	// ********************
	function automatic void interpret_program();
		logic [`XLEN-1:0] regs [`REG_COUNT];
		logic [`XLEN-1:0] mem [DMEM_WORDS];
		logic [`XLEN-1:0] w;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] imm_i;
		logic [`XLEN-1:0] imm_s;
		logic [`XLEN-1:0] res;
		logic [`XLEN-1:0] ea;
		logic             wen;
		regs    = '{default: '0};
		regs[2] = `INIT_SP;
		mem     = dmem_init;
		for (int pc = 0; pc < PROG_LEN; pc++) begin
			w     = prog[pc];
			a     = regs[w[19:15]];
			b     = regs[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			res   = '0;
			wen   = 1'b1;
			case (w[6:0])
				rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
					if (w[6:0] == rv_isa_pkg::OPC_OP_IMM) begin
						b = imm_i;
					end
					case (w[14:12])
						3'b000: res = (w[6:0] == rv_isa_pkg::OPC_OP && w[30]) ? a - b : a + b;
						3'b100: res = a ^ b;
						3'b110: res = a | b;
						3'b111: res = a & b;
						default: wen = 1'b0;
					endcase
				end
				rv_isa_pkg::OPC_LUI: res = {w[31:12], 12'b0};
				// Word index wraps at the model memory size
				rv_isa_pkg::OPC_LOAD: begin
					ea  = a + imm_i;
					res = mem[ea[10:2]];
				end
				rv_isa_pkg::OPC_STORE: begin
					ea            = a + imm_s;
					mem[ea[10:2]] = b;
					wen           = 1'b0;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
				end
				default: wen = 1'b0;
			endcase
			if (wen && w[11:7] != 5'd0) begin
				regs[w[11:7]] = res;
			end
		end
	endfunction

	initial begin
		done            = 1'b0;
		value_errors    = 0;
		count_errors    = 0;
		protocol_errors = 0;
		n_store         = 0;
		n_fetch         = 0;
		seen_cmd        = 1'b0;
		@(posedge arst_n);
		interpret_program();
	end

	// ********************
	// Port monitor
	// ********************
	always @(negedge clk) begin
		if (!arst_n) begin
			if (inst_start || d_req.cmd != core_pipe_pkg::DMEM_NONE) begin
				$display("A memory request was raised while reset is asserted");
				protocol_errors++;
			end
		end else if (!done) begin
			if (inst_start && inst_ready) begin
				if (n_fetch == 0 && i_addr !== `RESET_PC) begin
					$display("[FAIL] first fetch address: expected %h actual %h",
						`RESET_PC, i_addr);
					value_errors++;
				end
				n_fetch++;
			end
			// First memory instruction of the program is a store
			if (d_req.cmd != core_pipe_pkg::DMEM_NONE && !seen_cmd) begin
				seen_cmd = 1'b1;
				if (d_req.cmd != core_pipe_pkg::DMEM_WRITE) begin
					$display("A data command appeared before the first store reached memory");
					protocol_errors++;
				end
			end
			if (d_req.cmd == core_pipe_pkg::DMEM_WRITE && d_cmd_ready) begin
				if (n_store >= exp_addr.size()) begin
					$display("Extra store to %h beyond the %0d expected stores", d_req.addr,
						exp_addr.size());
					count_errors++;
				end else begin
					if (d_req.addr !== exp_addr[n_store]) begin
						$display("[FAIL] store %0d address: expected %h actual %h", n_store,
							exp_addr[n_store], d_req.addr);
						value_errors++;
					end
					if (d_req.wdata !== exp_data[n_store]) begin
						$display("[FAIL] store %0d data: expected %h actual %h", n_store,
							exp_data[n_store], d_req.wdata);
						value_errors++;
					end
					if (d_req.wmask !== FULL_MASK) begin
						$display("[FAIL] store %0d write mask: expected %h actual %h", n_store,
							FULL_MASK, d_req.wmask);
						value_errors++;
					end
				end
				n_store++;
			end
			// Fetch this far past the program means all of it has left the memory stage
			if (inst_start && inst_ready && i_addr >= 32'((PROG_LEN + 8) * 4)) begin
				if (n_store < exp_addr.size()) begin
					$display("Missing stores: only %0d of %0d stores reached the data port",
						n_store, exp_addr.size());
					count_errors++;
				end
				done = 1'b1;
			end
		end
	end

endmodule

// File: testbench/core_assertions.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module core_assertions (
	input logic                     clk,
	input logic                     arst_n,
	input logic                     inst_start,
	input logic                     inst_ready,
	input logic [`XLEN-1:0]         i_addr,
	input core_pipe_pkg::dmem_req_t d_req,
	input logic                     d_cmd_ready,
	input logic                     rdata_valid
);

	int   fail_count = 0;
	logic read_open;

	// Read accepted and data not yet returned
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			read_open <= 1'b0;
		end else if (rdata_valid) begin
			read_open <= 1'b0;
		end else if (d_req.cmd == core_pipe_pkg::DMEM_READ && d_cmd_ready) begin
			read_open <= 1'b1;
		end
	end

	inst_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		inst_start && !inst_ready |=> inst_start && $stable(i_addr))
		else begin
			$error("Instruction request dropped or changed before acceptance");
			fail_count++;
		end

	data_req_held: assert property (@(posedge clk) disable iff (!arst_n)
		(d_req.cmd != core_pipe_pkg::DMEM_NONE) && !d_cmd_ready |=> $stable(d_req))
		else begin
			$error("Data command dropped or changed before acceptance");
			fail_count++;
		end

	one_read_open: assert property (@(posedge clk) disable iff (!arst_n)
		read_open |-> d_req.cmd == core_pipe_pkg::DMEM_NONE)
		else begin
			$error("New data command while a read is outstanding");
			fail_count++;
		end

endmodule

bind core_pipeline core_assertions assert0 (.*);

// File: hw/core_pipeline.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module core_pipeline (
	input  logic                     clk,
	input  logic                     arst_n,
	output logic                     inst_start,
	input  logic                     inst_ready,
	output logic [`XLEN-1:0]         i_addr,
	input  logic [`XLEN-1:0]         inst,
	input  logic                     inst_valid,
	output core_pipe_pkg::dmem_req_t d_req,
	input  logic                     d_cmd_ready,
	input  logic [`XLEN-1:0]         rdata,
	input  logic                     rdata_valid
);

	logic                      f_valid;
	logic                      f_ready;
	core_pipe_pkg::fetch_pl_t  f_data;
	logic                      d_in_valid;
	logic                      d_in_ready;
	core_pipe_pkg::fetch_pl_t  d_in_data;
	logic                      d_valid;
	logic                      d_ready;
	core_pipe_pkg::exec_pl_t   d_data;
	logic                      x_valid;
	logic                      x_ready;
	core_pipe_pkg::exec_pl_t   x_in_data;
	core_pipe_pkg::mem_pl_t    x_data;
	logic                      m_valid;
	logic                      m_ready;
	core_pipe_pkg::mem_pl_t    m_in_data;
	core_pipe_pkg::wb_t        wb;

	// ********************
	// Fetch and decode
	// ********************
	fetch_stage fetch0 (
		.clk(clk), .arst_n(arst_n),
		.inst_start(inst_start), .inst_ready(inst_ready), .i_addr(i_addr),
		.inst(inst), .inst_valid(inst_valid),
		.out_valid(f_valid), .out_ready(f_ready), .out_data(f_data)
	);

	stage_reg #(.payload_t(core_pipe_pkg::fetch_pl_t)) fd_reg0 (
		.clk(clk), .arst_n(arst_n),
		.in_valid(f_valid), .in_ready(f_ready), .in_data(f_data),
		.out_valid(d_in_valid), .out_ready(d_in_ready), .out_data(d_in_data)
	);

	decode_stage decode0 (
		.clk(clk), .arst_n(arst_n),
		.in_valid(d_in_valid), .in_ready(d_in_ready), .in_data(d_in_data),
		.out_valid(d_valid), .out_ready(d_ready), .out_data(d_data), .wb(wb)
	);

	// ********************
	// Execute and memory
	// ********************
	stage_reg #(.payload_t(core_pipe_pkg::exec_pl_t)) de_reg0 (
		.clk(clk), .arst_n(arst_n),
		.in_valid(d_valid), .in_ready(d_ready), .in_data(d_data),
		.out_valid(x_valid), .out_ready(x_ready), .out_data(x_in_data)
	);

	// Execute is combinational so its handshake runs straight through
	execute_stage execute0 (
		.in_data(x_in_data), .out_data(x_data)
	);

	stage_reg #(.payload_t(core_pipe_pkg::mem_pl_t)) em_reg0 (
		.clk(clk), .arst_n(arst_n),
		.in_valid(x_valid), .in_ready(x_ready), .in_data(x_data),
		.out_valid(m_valid), .out_ready(m_ready), .out_data(m_in_data)
	);

	memory_stage memory0 (
		.clk(clk), .arst_n(arst_n),
		.in_valid(m_valid), .in_ready(m_ready), .in_data(m_in_data),
		.d_req(d_req), .d_cmd_ready(d_cmd_ready),
		.rdata(rdata), .rdata_valid(rdata_valid), .wb(wb)
	);

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module memory_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  core_pipe_pkg::mem_pl_t   in_data,
	output core_pipe_pkg::dmem_req_t d_req,
	input  logic                     d_cmd_ready,
	input  logic [`XLEN-1:0]         rdata,
	input  logic                     rdata_valid,
	output core_pipe_pkg::wb_t       wb
);

	logic read_pending;
	logic alu_done;

	assign alu_done = in_valid && !in_data.mem_read && !in_data.mem_write;

	// ********************
	// Data command
	// ********************
	always_comb begin
		d_req.cmd = core_pipe_pkg::DMEM_NONE;
		if (in_valid && !read_pending) begin
			if (in_data.mem_write) begin
				d_req.cmd = core_pipe_pkg::DMEM_WRITE;
			end else if (in_data.mem_read) begin
				d_req.cmd = core_pipe_pkg::DMEM_READ;
			end
		end
		d_req.addr  = in_data.alu_out;
		d_req.wdata = in_data.store_data;
		// Word accesses only
		d_req.wmask = '1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			read_pending <= 1'b0;
		end else if (read_pending) begin
			if (rdata_valid) begin
				read_pending <= 1'b0;
			end
		end else if (d_req.cmd == core_pipe_pkg::DMEM_READ && d_cmd_ready) begin
			read_pending <= 1'b1;
		end
	end

	// Store leaves at acceptance, load leaves with its data
	always_comb begin
		if (read_pending) begin
			in_ready = rdata_valid;
		end else if (in_data.mem_write) begin
			in_ready = d_cmd_ready;
		end else begin
			in_ready = !in_data.mem_read;
		end
	end

	// ********************
	// Writeback record
	// ********************
	always_comb begin
		wb.rd = in_data.rd;
		if (read_pending) begin
			wb.valid = rdata_valid && in_data.rf_wen;
			wb.data  = rdata;
		end else begin
			wb.valid = alu_done && in_data.rf_wen;
			wb.data  = in_data.alu_out;
		end
	end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module execute_stage (
	input  core_pipe_pkg::exec_pl_t in_data,
	output core_pipe_pkg::mem_pl_t  out_data
);

	logic [`XLEN-1:0] result;

	// Address for loads and stores, rd value for the rest
	always_comb begin
		case (in_data.alu_op)
			rv_isa_pkg::ALU_ADD:    result = in_data.op1 + in_data.op2;
			rv_isa_pkg::ALU_SUB:    result = in_data.op1 - in_data.op2;
			rv_isa_pkg::ALU_AND:    result = in_data.op1 & in_data.op2;
			rv_isa_pkg::ALU_OR:     result = in_data.op1 | in_data.op2;
			rv_isa_pkg::ALU_XOR:    result = in_data.op1 ^ in_data.op2;
			rv_isa_pkg::ALU_PASS_B: result = in_data.op2;
			default:                result = '0;
		endcase
	end

	always_comb begin
		out_data.alu_out    = result;
		out_data.store_data = in_data.rs2_data;
		out_data.mem_read   = in_data.mem_read;
		out_data.mem_write  = in_data.mem_write;
		out_data.rf_wen     = in_data.rf_wen;
		out_data.rd         = in_data.rd;
	end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module decode_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  core_pipe_pkg::fetch_pl_t in_data,
	output logic                     out_valid,
	input  logic                     out_ready,
	output core_pipe_pkg::exec_pl_t  out_data,
	input  core_pipe_pkg::wb_t       wb
);

	rv_isa_pkg::inst_fields_t f;
	rv_isa_pkg::opcode_e      opcode;
	rv_isa_pkg::funct3_e      funct3;
	rv_isa_pkg::word_t        imm_i;
	rv_isa_pkg::word_t        imm_s;
	rv_isa_pkg::word_t        imm_u;
	rv_isa_pkg::word_t        rs1_val;
	rv_isa_pkg::word_t        rs2_val;
	rv_isa_pkg::alu_op_e      f3_op;
	logic                     f3_known;
	logic                     f7_known;
	logic                     use_rs1;
	logic                     use_rs2;
	logic                     writes_rd;
	logic                     rs1_busy;
	logic                     rs2_busy;
	logic                     rd_busy;
	logic                     hazard;
	logic [`XLEN-1:0]         regs [`REG_COUNT];
	logic [`REG_COUNT-1:0]    pending;

	// ********************
	// Fields and immediates
	// ********************
	assign f      = rv_isa_pkg::inst_fields_t'(in_data.inst);
	assign opcode = rv_isa_pkg::opcode_e'(f.opcode);
	assign funct3 = rv_isa_pkg::funct3_e'(f.funct3);
	assign imm_i  = {{20{in_data.inst[31]}}, in_data.inst[31:20]};
	assign imm_s  = {{20{in_data.inst[31]}}, in_data.inst[31:25], in_data.inst[11:7]};
	assign imm_u  = {in_data.inst[31:12], 12'b0};

	// Same-cycle writeback wins over the array
	assign rs1_val = (f.rs1 == '0) ? '0 :
		(wb.valid && wb.rd == f.rs1) ? wb.data : regs[f.rs1];
	assign rs2_val = (f.rs2 == '0) ? '0 :
		(wb.valid && wb.rd == f.rs2) ? wb.data : regs[f.rs2];

	always_comb begin
		f3_known = 1'b1;
		case (funct3)
			rv_isa_pkg::F3_ADD: f3_op = rv_isa_pkg::ALU_ADD;
			rv_isa_pkg::F3_XOR: f3_op = rv_isa_pkg::ALU_XOR;
			rv_isa_pkg::F3_OR:  f3_op = rv_isa_pkg::ALU_OR;
			rv_isa_pkg::F3_AND: f3_op = rv_isa_pkg::ALU_AND;
			default: begin
				f3_op    = rv_isa_pkg::ALU_ADD;
				f3_known = 1'b0;
			end
		endcase
	end

	// SUB is the only alternate encoding kept
	assign f7_known = (f.funct7 == rv_isa_pkg::F7_BASE) ||
		(f.funct7 == rv_isa_pkg::F7_ALT && funct3 == rv_isa_pkg::F3_ADD);

	always_comb begin
		out_data.alu_op    = rv_isa_pkg::ALU_ADD;
		out_data.op1       = rs1_val;
		out_data.op2       = imm_i;
		out_data.rs2_data  = rs2_val;
		out_data.mem_read  = 1'b0;
		out_data.mem_write = 1'b0;
		out_data.rd        = f.rd;
		use_rs1            = 1'b0;
		use_rs2            = 1'b0;
		writes_rd          = 1'b0;
		case (opcode)
			rv_isa_pkg::OPC_OP: begin
				use_rs1         = 1'b1;
				use_rs2         = 1'b1;
				writes_rd       = f3_known && f7_known;
				out_data.op2    = rs2_val;
				out_data.alu_op = (f.funct7 == rv_isa_pkg::F7_ALT) ? rv_isa_pkg::ALU_SUB : f3_op;
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				use_rs1         = 1'b1;
				writes_rd       = f3_known;
				out_data.alu_op = f3_op;
			end
			rv_isa_pkg::OPC_LUI: begin
				writes_rd       = 1'b1;
				out_data.op2    = imm_u;
				out_data.alu_op = rv_isa_pkg::ALU_PASS_B;
			end
			rv_isa_pkg::OPC_LOAD: begin
				use_rs1           = 1'b1;
				writes_rd         = 1'b1;
				out_data.mem_read = 1'b1;
			end
			rv_isa_pkg::OPC_STORE: begin
				use_rs1            = 1'b1;
				use_rs2            = 1'b1;
				out_data.op2       = imm_s;
				out_data.mem_write = 1'b1;
			end
			// Anything else retires with no effect
			default: writes_rd = 1'b0;
		endcase
		out_data.rf_wen = writes_rd && (f.rd != '0);
	end

	// ********************
	// Scoreboard and stall
	// ********************
	assign rs1_busy = pending[f.rs1] && !(wb.valid && wb.rd == f.rs1);
	assign rs2_busy = pending[f.rs2] && !(wb.valid && wb.rd == f.rs2);
	assign rd_busy  = pending[f.rd] && !(wb.valid && wb.rd == f.rd);
	// Destination check keeps writebacks of the same register in order
	assign hazard = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy) ||
		(out_data.rf_wen && rd_busy);

	assign out_valid = in_valid && !hazard;
	assign in_ready  = out_ready && !hazard;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= '0;
		end else begin
			if (wb.valid) begin
				pending[wb.rd] <= 1'b0;
			end
			if (out_valid && out_ready && out_data.rf_wen) begin
				pending[out_data.rd] <= 1'b1;
			end
		end
	end

	// Register file with x2 as initial stack pointer
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= (i == 2) ? `INIT_SP : '0;
			end
		end else if (wb.valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/10ps
`include "core_consts.svh"

module fetch_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	output logic                     inst_start,
	input  logic                     inst_ready,
	output logic [`XLEN-1:0]         i_addr,
	input  logic [`XLEN-1:0]         inst,
	input  logic                     inst_valid,
	output logic                     out_valid,
	input  logic                     out_ready,
	output core_pipe_pkg::fetch_pl_t out_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT,
		ST_HOLD
	} state_e;

	state_e           state;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] held_inst;
	logic             handoff;

	assign inst_start = (state == ST_REQ);
	assign i_addr     = pc;

	// Returned word goes straight through unless downstream is full
	assign out_valid = (state == ST_HOLD) || (state == ST_WAIT && inst_valid);
	assign handoff   = out_valid && out_ready;

	always_comb begin
		out_data.pc   = pc;
		out_data.inst = (state == ST_HOLD) ? held_inst : inst;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			pc    <= `RESET_PC;
		end else begin
			case (state)
				ST_IDLE: state <= ST_REQ;
				ST_REQ: begin
					if (inst_ready) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (inst_valid && !out_ready) begin
						state <= ST_HOLD;
					end
				end
				default: state <= state;
			endcase
			// Next sequential address once the word is taken
			if (handoff) begin
				pc    <= pc + `XLEN'(4);
				state <= ST_REQ;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_WAIT && inst_valid) begin
			held_inst <= inst;
		end
	end

endmodule

// File: hw/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// Accept when empty or when the held item leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

// File: hw/core_pipe_pkg.sv
`include "core_consts.svh"

package core_pipe_pkg;

	// Fetch to decode
	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] inst;
	} fetch_pl_t;

	// Decode to execute
	typedef struct packed {
		logic [`XLEN-1:0]    op1;
		logic [`XLEN-1:0]    op2;
		logic [`XLEN-1:0]    rs2_data;
		rv_isa_pkg::alu_op_e alu_op;
		logic                mem_read;
		logic                mem_write;
		logic                rf_wen;
		rv_isa_pkg::reg_idx_t rd;
	} exec_pl_t;

	// Execute to memory
	typedef struct packed {
		logic [`XLEN-1:0]     alu_out;
		logic [`XLEN-1:0]     store_data;
		logic                 mem_read;
		logic                 mem_write;
		logic                 rf_wen;
		rv_isa_pkg::reg_idx_t rd;
	} mem_pl_t;

	// Register write from the memory stage back into decode
	typedef struct packed {
		logic                 valid;
		rv_isa_pkg::reg_idx_t rd;
		logic [`XLEN-1:0]     data;
	} wb_t;

	typedef enum logic [2:0] {
		DMEM_NONE  = 3'd0,
		DMEM_READ  = 3'd1,
		DMEM_WRITE = 3'd2
	} dmem_cmd_e;

	typedef struct packed {
		dmem_cmd_e        cmd;
		logic [`XLEN-1:0] addr;
		logic [`XLEN-1:0] wdata;
		logic [`XLEN-1:0] wmask;
	} dmem_req_t;

endpackage

// File: hw/rv_isa_pkg.sv
`include "core_consts.svh"

package rv_isa_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	typedef enum logic [2:0] {
		F3_ADD = 3'b000,
		F3_XOR = 3'b100,
		F3_OR  = 3'b110,
		F3_AND = 3'b111
	} funct3_e;

	// Upper function bits of R-type
	typedef enum logic [6:0] {
		F7_BASE = 7'b0000000,
		F7_ALT  = 7'b0100000
	} funct7_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	// R-type field layout; the other formats share these positions
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} inst_fields_t;

endpackage

// File: include/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ********************
// Core dimensions
// ********************

// Data path and address width in bits
`define XLEN 32

// Architectural registers including x0
`define REG_COUNT 32

// ********************
// Reset values
// ********************

// First fetch address
`define RESET_PC 32'h0000_0000

// Stack pointer x2 after reset
`define INIT_SP 32'd1000

`endif
